// File: Makefile
TOP := tb_mem_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run, pass when sim.log holds the pass line"
	@echo "  make clean  remove obj_dir and sim.log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log || true
	@cat sim.log
	@grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
mem_cfg_pkg.sv
mem_msg_pkg.sv
mem_fifo.sv
mem_dispatch.sv
mem_bank.sv
mem_collect.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
    parameter int ROWS    = 64,
    parameter int CREDITS = 2
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    push,
    input  wire logic                    req_write,
    input  wire logic [$clog2(ROWS)-1:0] req_row,
    input  wire mem_cfg_pkg::word_t      req_wdata,
    input  wire mem_cfg_pkg::mask_t      req_wmask,
    output logic                         credit_ret,
    output logic                         resp_valid,
    output mem_cfg_pkg::word_t           resp_data,
    input  wire logic                    resp_take
);

    import mem_cfg_pkg::*;
    import mem_msg_pkg::*;

    localparam int ROW_BITS = $clog2(ROWS);

    bank_req_t           in_req;
    bank_req_t           head;
    logic                q_empty;
    logic                q_full;
    logic                pop;
    logic [ROW_BITS-1:0] row;
    word_t               ram [ROWS];

    assign in_req.write = req_write;
    assign in_req.row   = ROW_BITS_MAX'(req_row);
    assign in_req.wdata = req_wdata;
    assign in_req.wmask = req_wmask;

    // queue depth equals the credits handed to the dispatcher.
    mem_fifo #(
        .item_t (bank_req_t),
        .DEPTH  (CREDITS)
    ) u_req_q (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (in_req),
        .pop       (pop),
        .head      (head),
        .empty     (q_empty),
        .full      (q_full)
    );

    assign pop        = !q_empty && (!resp_valid || resp_take); // output free.
    assign credit_ret = pop;
    assign row        = head.row[ROW_BITS-1:0];

    always_ff @(posedge clk) begin
        if (pop) begin
            if (head.write) begin
                ram[row] <= (ram[row] & ~head.wmask) | (head.wdata & head.wmask);
            end else begin
                resp_data <= ram[row]; // held until taken.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (pop && !head.write) begin
            resp_valid <= 1'b1;
        end else if (resp_take) begin
            resp_valid <= 1'b0;
        end
    end

    // a push into a full queue means the dispatcher lost track of credits.
    a_credit_sync: assert property (@(posedge clk) disable iff (rst) push |-> !q_full);

endmodule

`default_nettype wire

// File: mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

    // data path and byte address width.
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // byte address, bits [1:0] are ignored.
    typedef logic [XLEN-1:0] addr_t;

    // one bit per data bit. a set bit takes wdata, a clear bit keeps the old bit.
    typedef logic [XLEN-1:0] mask_t;

endpackage

`default_nettype wire

// File: mem_collect.sv
`timescale 1ns/1ps
`default_nettype none

module mem_collect #(
    parameter int NUM_BANKS   = 4,
    parameter int ORDER_DEPTH = 8
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         ord_push,
    input  wire mem_msg_pkg::port_e           ord_port,
    input  wire logic [$clog2(NUM_BANKS)-1:0] ord_bank,
    output logic                              ord_full,
    input  wire logic [NUM_BANKS-1:0]         resp_valid,
    input  wire mem_cfg_pkg::word_t           resp_data [NUM_BANKS],
    output logic [NUM_BANKS-1:0]              resp_take,
    output mem_cfg_pkg::word_t                inst,
    output logic                              inst_valid,
    output mem_cfg_pkg::word_t                rdata,
    output logic                              rdata_valid
);

    import mem_msg_pkg::*;

    localparam int BANK_BITS = $clog2(NUM_BANKS);

    order_t               in_ord;
    order_t               head;
    logic                 q_empty;
    logic                 hit;
    logic [BANK_BITS-1:0] head_bank;

    assign in_ord.port = ord_port;
    assign in_ord.bank = BANK_BITS_MAX'(ord_bank);

    mem_fifo #(
        .item_t (order_t),
        .DEPTH  (ORDER_DEPTH)
    ) u_order_q (
        .clk       (clk),
        .rst       (rst),
        .push      (ord_push),
        .push_data (in_ord),
        .pop       (hit),
        .head      (head),
        .empty     (q_empty),
        .full      (ord_full)
    );

    // only the oldest read may complete.
    assign head_bank = head.bank[BANK_BITS-1:0];
    assign hit       = !q_empty && resp_valid[head_bank];
    assign resp_take = hit ? (NUM_BANKS'(1) << head_bank) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid  <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            inst_valid  <= hit && (head.port == PORT_INST);
            rdata_valid <= hit && (head.port == PORT_DATA);
        end
    end

    always_ff @(posedge clk) begin
        if (hit && head.port == PORT_INST) inst <= resp_data[head_bank];
        if (hit && head.port == PORT_DATA) rdata <= resp_data[head_bank];
    end

endmodule

`default_nettype wire

// File: mem_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module mem_dispatch #(
    parameter int NUM_BANKS = 4,
    parameter int ROWS      = 64,
    parameter int CREDITS   = 2
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        inst_start,
    input  wire mem_cfg_pkg::addr_t          i_addr,
    input  wire logic                        d_cmd_start,
    input  wire logic                        d_cmd_write,
    input  wire mem_cfg_pkg::addr_t          d_addr,
    input  wire mem_cfg_pkg::word_t          wdata,
    input  wire mem_cfg_pkg::mask_t          wmask,
    output logic                             inst_ready,
    output logic                             d_cmd_ready,
    output logic [NUM_BANKS-1:0]             bank_push,
    output logic                             req_write,
    output logic [$clog2(ROWS)-1:0]          req_row,
    output mem_cfg_pkg::word_t               req_wdata,
    output mem_cfg_pkg::mask_t               req_wmask,
    input  wire logic [NUM_BANKS-1:0]        credit_ret,
    output logic                             ord_push,
    output mem_msg_pkg::port_e               ord_port,
    output logic [$clog2(NUM_BANKS)-1:0]     ord_bank,
    input  wire logic                        ord_full
);

    import mem_msg_pkg::*;

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int ROW_BITS  = $clog2(ROWS);
    localparam int CNT_BITS  = $clog2(CREDITS + 1);

    logic [BANK_BITS-1:0] i_bank;
    logic [BANK_BITS-1:0] d_bank;
    logic [BANK_BITS-1:0] acc_bank;
    logic [ROW_BITS-1:0]  i_row;
    logic [ROW_BITS-1:0]  d_row;
    logic [NUM_BANKS-1:0] has_credit;
    logic [NUM_BANKS-1:0] take;
    logic                 acc_inst;
    logic                 acc_data;
    logic                 accept;
    logic [CNT_BITS-1:0]  credit [NUM_BANKS];

    // word interleave, bank bits sit right above the byte offset.
    assign i_bank = i_addr[2 +: BANK_BITS];
    assign d_bank = d_addr[2 +: BANK_BITS];
    assign i_row  = i_addr[2 + BANK_BITS +: ROW_BITS];
    assign d_row  = d_addr[2 + BANK_BITS +: ROW_BITS];

    // data port wins a tie.
    assign d_cmd_ready = has_credit[d_bank] && (d_cmd_write || !ord_full);
    assign acc_data    = d_cmd_start && d_cmd_ready;
    assign inst_ready  = !acc_data && has_credit[i_bank] && !ord_full;
    assign acc_inst    = inst_start && inst_ready;
    assign accept      = acc_data || acc_inst;
    assign acc_bank    = acc_data ? d_bank : i_bank;

    assign ord_push = acc_inst || (acc_data && !d_cmd_write); // reads only.
    assign ord_port = acc_data ? PORT_DATA : PORT_INST;
    assign ord_bank = acc_bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_push <= '0;
        end else begin
            bank_push <= accept ? (NUM_BANKS'(1) << acc_bank) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_write <= acc_data && d_cmd_write;
            req_row   <= acc_data ? d_row : i_row;
            req_wdata <= wdata;
            req_wmask <= wmask;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_credit
        assign take[b]       = accept && (acc_bank == BANK_BITS'(b));
        assign has_credit[b] = (credit[b] != '0);

        // spent at acceptance, given back when the bank pops.
        always_ff @(posedge clk) begin
            if (rst) begin
                credit[b] <= CNT_BITS'(CREDITS);
            end else if (take[b] && !credit_ret[b]) begin
                credit[b] <= credit[b] - 1'b1;
            end else if (credit_ret[b] && !take[b]) begin
                credit[b] <= credit[b] + 1'b1;
            end
        end

        a_credit_over: assert property (@(posedge clk) disable iff (rst)
            (credit_ret[b] && !take[b]) |-> (credit[b] < CNT_BITS'(CREDITS)));
    end

endmodule

`default_nettype wire

// File: mem_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  push,
    input  wire item_t push_data,
    input  wire logic  pop,
    output item_t      head,
    output logic       empty,
    output logic       full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    item_t               store [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // depth need not be a power of two.
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head  = store[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_BITS'(DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) store[wr_ptr] <= push_data;
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

// File: mem_msg_pkg.sv
`default_nettype none

package mem_msg_pkg;

    // widest row and bank fields any configuration can ask for.
    localparam int ROW_BITS_MAX  = 32;
    localparam int BANK_BITS_MAX = 3;

    typedef enum logic {
        PORT_INST = 1'b0,
        PORT_DATA = 1'b1
    } port_e;

    // queued bank request. the row is zero extended.
    typedef struct packed {
        logic                    write;
        logic [ROW_BITS_MAX-1:0] row;
        mem_cfg_pkg::word_t      wdata;
        mem_cfg_pkg::mask_t      wmask;
    } bank_req_t;

    // one outstanding read, in acceptance order.
    typedef struct packed {
        port_e                    port;
        logic [BANK_BITS_MAX-1:0] bank;
    } order_t;

endpackage

`default_nettype wire

// File: mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
    parameter int NUM_BANKS   = 4,
    parameter int ROWS        = 64,
    parameter int CREDITS     = 2,
    parameter int ORDER_DEPTH = 8
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               inst_start,
    output wire logic               inst_ready,
    input  wire mem_cfg_pkg::addr_t i_addr,
    output wire mem_cfg_pkg::word_t inst,
    output wire logic               inst_valid,
    input  wire logic               d_cmd_start,
    input  wire logic               d_cmd_write,
    output wire logic               d_cmd_ready,
    input  wire mem_cfg_pkg::addr_t d_addr,
    input  wire mem_cfg_pkg::word_t wdata,
    input  wire mem_cfg_pkg::mask_t wmask,
    output wire mem_cfg_pkg::word_t rdata,
    output wire logic               rdata_valid
);

    import mem_cfg_pkg::*;
    import mem_msg_pkg::*;

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int ROW_BITS  = $clog2(ROWS);

    wire logic [NUM_BANKS-1:0] bank_push;
    wire logic                 req_write;
    wire logic [ROW_BITS-1:0]  req_row;
    wire word_t                req_wdata;
    wire mask_t                req_wmask;
    wire logic [NUM_BANKS-1:0] credit_ret;
    wire logic                 ord_push;
    wire port_e                ord_port;
    wire logic [BANK_BITS-1:0] ord_bank;
    wire logic                 ord_full;
    wire logic [NUM_BANKS-1:0] resp_valid;
    wire word_t                resp_data [NUM_BANKS];
    wire logic [NUM_BANKS-1:0] resp_take;

    mem_dispatch #(
        .NUM_BANKS (NUM_BANKS),
        .ROWS      (ROWS),
        .CREDITS   (CREDITS)
    ) u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .inst_start  (inst_start),
        .i_addr      (i_addr),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .inst_ready  (inst_ready),
        .d_cmd_ready (d_cmd_ready),
        .bank_push   (bank_push),
        .req_write   (req_write),
        .req_row     (req_row),
        .req_wdata   (req_wdata),
        .req_wmask   (req_wmask),
        .credit_ret  (credit_ret),
        .ord_push    (ord_push),
        .ord_port    (ord_port),
        .ord_bank    (ord_bank),
        .ord_full    (ord_full)
    );

    // banks share the issue fields, each has its own push.
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_bank #(
            .ROWS    (ROWS),
            .CREDITS (CREDITS)
        ) u_bank (
            .clk        (clk),
            .rst        (rst),
            .push       (bank_push[b]),
            .req_write  (req_write),
            .req_row    (req_row),
            .req_wdata  (req_wdata),
            .req_wmask  (req_wmask),
            .credit_ret (credit_ret[b]),
            .resp_valid (resp_valid[b]),
            .resp_data  (resp_data[b]),
            .resp_take  (resp_take[b])
        );
    end

    mem_collect #(
        .NUM_BANKS   (NUM_BANKS),
        .ORDER_DEPTH (ORDER_DEPTH)
    ) u_collect (
        .clk         (clk),
        .rst         (rst),
        .ord_push    (ord_push),
        .ord_port    (ord_port),
        .ord_bank    (ord_bank),
        .ord_full    (ord_full),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_take   (resp_take),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    import mem_cfg_pkg::*;

    localparam int NUM_BANKS   = 4;
    localparam int ROWS        = 64;
    localparam int ORDER_DEPTH = 8;
    localparam int WORDS       = NUM_BANKS * ROWS;
    localparam int PERIOD      = 40;
    localparam int N1          = 16;  // words filled in test 1.
    localparam int N2          = 16;
    localparam int N3          = 16;  // fetch and load pairs.
    localparam int N4          = 8;
    localparam int N5          = 32;
    localparam int N6          = 200;
    localparam int TOTAL_OPS   = 3 * N1 + N2 + 2 * N3 + 3 * N4 + 8 + N5 + 2 * N6;
    localparam int WATCHDOG_NS = (TOTAL_OPS * 20 + 8) * PERIOD;
    localparam int DRAIN_LIMIT = 20 * ORDER_DEPTH;

    logic  clk;
    logic  rst;
    logic  inst_start;
    logic  inst_ready;
    addr_t i_addr;
    word_t inst;
    logic  inst_valid;
    logic  d_cmd_start;
    logic  d_cmd_write;
    logic  d_cmd_ready;
    addr_t d_addr;
    word_t wdata;
    mask_t wmask;
    word_t rdata;
    logic  rdata_valid;

    // reference memory, filled at acceptance.
    word_t  model_mem [WORDS];
    bit     written [WORDS];
    word_t  exp_inst [$];
    word_t  exp_data [$];
    integer seed;
    int     fill_idx [N1];
    int     errors;
    int     mon_errors;
    int     reads;
    int     resps;
    int     base_reads;
    int     base_resps;
    int     stalls;
    int     d_wait;
    int     tests_done;

    mem_subsystem u_mem_subsystem (
        .clk         (clk),
        .rst         (rst),
        .inst_start  (inst_start),
        .inst_ready  (inst_ready),
        .i_addr      (i_addr),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_cmd_ready (d_cmd_ready),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic mask_t rand_mask();
        return (rand_below(4) == 0) ? '1 : mask_t'($random(seed));
    endfunction

    // unwritten words hold x in the ram, so they get a full mask.
    function automatic mask_t store_mask(input int idx);
        return written[idx] ? rand_mask() : '1;
    endfunction

    function automatic addr_t to_addr(input int idx);
        addr_t a;
        a = addr_t'(idx) << 2;
        a[1:0] = 2'(rand_below(4)); // byte offset is ignored.
        return a;
    endfunction

    function automatic int word_idx(input addr_t a);
        return int'(a >> 2) % WORDS;
    endfunction

    function automatic int pick_written();
        int idx;
        idx = rand_below(WORDS);
        while (!written[idx]) idx = (idx + 1) % WORDS;
        return idx;
    endfunction

    task automatic check_word(input word_t exp, input word_t act, input string what);
        if (exp !== act) begin
            $display("FAILED at %0t ns: %s expected %08h, got %08h", $time, what, exp, act);
            mon_errors++;
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (exp != act) begin
            $display("FAILED at %0t ns: %s expected %0d responses, got %0d",
                     $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // holds start and fields until each requested port is accepted.
    task automatic issue(input bit do_i, input int i_idx, input bit do_d, input bit d_wr,
                         input int d_idx, input word_t wd, input mask_t wm);
        bit i_pend;
        bit d_pend;
        i_pend      = do_i;
        d_pend      = do_d;
        d_wait      = 0;
        inst_start  = do_i;
        i_addr      = to_addr(i_idx);
        d_cmd_start = do_d;
        d_cmd_write = d_wr;
        d_addr      = to_addr(d_idx);
        wdata       = wd;
        wmask       = wm;
        while (i_pend || d_pend) begin
            @(negedge clk);
            if (d_pend && d_cmd_ready) d_pend = 1'b0;
            if (i_pend && inst_ready) i_pend = 1'b0;
            if (d_pend) d_wait++;
            if (i_pend || d_pend) stalls++;
            @(posedge clk);
            #2;
            inst_start  = i_pend;
            d_cmd_start = d_pend;
        end
    endtask

    task automatic store(input int idx, input word_t wd, input mask_t wm);
        issue(1'b0, 0, 1'b1, 1'b1, idx, wd, wm);
    endtask

    task automatic load(input int idx);
        issue(1'b0, 0, 1'b1, 1'b0, idx, '0, '0);
    endtask

    task automatic fetch(input int idx);
        issue(1'b1, idx, 1'b0, 1'b0, 0, '0, '0);
    endtask

    task automatic start_test();
        base_reads = reads;
        base_resps = resps;
        stalls     = 0;
    endtask

    task automatic end_test(input string name);
        int n;
        n = 0;
        while ((exp_inst.size() != 0 || exp_data.size() != 0) && n < DRAIN_LIMIT) begin
            idle(1);
            n++;
        end
        if (n == DRAIN_LIMIT) begin
            $display("ERROR at %0t ns: %s still waits for responses after %0d cycles",
                     $time, name, n);
            errors++;
        end
        idle(2);
        check_count(reads - base_reads, resps - base_resps, name);
        tests_done++;
        $display("test %0d (%s) done: %0d reads, %0d responses, %0d errors so far",
                 tests_done, name, reads - base_reads, resps - base_resps,
                 errors + mon_errors);
    endtask

    // watches acceptances and responses where both are stable.
    always @(negedge clk) begin : monitor
        int d_idx;
        int i_idx;
        d_idx = word_idx(d_addr);
        i_idx = word_idx(i_addr);
        if (!rst) begin
            if (inst_valid) begin
                if (exp_inst.size() == 0) begin
                    $display("ERROR at %0t ns: fetch data came back with no fetch pending",
                             $time);
                    mon_errors++;
                end else begin
                    check_word(exp_inst.pop_front(), inst, "fetch");
                end
                resps++;
            end
            if (rdata_valid) begin
                if (exp_data.size() == 0) begin
                    $display("ERROR at %0t ns: load data came back with no load pending",
                             $time);
                    mon_errors++;
                end else begin
                    check_word(exp_data.pop_front(), rdata, "load");
                end
                resps++;
            end
            if (d_cmd_start && d_cmd_ready && inst_start && inst_ready) begin
                $display("ERROR at %0t ns: both ports were accepted in one cycle", $time);
                mon_errors++;
            end
            if (d_cmd_start && d_cmd_ready) begin
                if (d_cmd_write) begin
                    model_mem[d_idx] = (model_mem[d_idx] & ~wmask) | (wdata & wmask);
                    written[d_idx]   = 1'b1;
                end else begin
                    exp_data.push_back(model_mem[d_idx]);
                    reads++;
                end
            end
            if (inst_start && inst_ready) begin
                exp_inst.push_back(model_mem[i_idx]);
                reads++;
            end
        end
    end

    initial begin
        int bank;
        int kind;
        seed        = 32'hb2c4;
        rst         = 1'b1;
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        errors      = 0;
        mon_errors  = 0;
        reads       = 0;
        resps       = 0;
        d_wait      = 0;
        tests_done  = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        idle(2);

        start_test();
        for (int k = 0; k < N1; k++) begin
            fill_idx[k] = rand_below(WORDS);
            store(fill_idx[k], rand_word(), '1);
        end
        for (int k = 0; k < N1; k++) store(fill_idx[k], rand_word(), rand_mask());
        for (int k = 0; k < N1; k++) load(fill_idx[k]);
        end_test("store then load");

        start_test();
        for (int k = 0; k < N2; k++) fetch(fill_idx[k % N1]);
        end_test("fetch stored words");

        start_test();
        for (int k = 0; k < N3; k++) begin
            // empty pipeline, so only the tie can hold the data port back.
            while (exp_inst.size() != 0 || exp_data.size() != 0) begin
                idle(1);
            end
            issue(1'b1, pick_written(), 1'b1, 1'b0, pick_written(), '0, '0);
            if (d_wait != 0) begin
                $display("ERROR at %0t ns: data port lost a tie to the fetch port", $time);
                errors++;
            end
        end
        end_test("fetch and load together");

        start_test();
        for (int k = 0; k < N4; k++) begin
            bank = pick_written();
            load(bank);
            store(bank, rand_word(), rand_mask());
            load(bank);
        end
        end_test("read before store");

        // one bank only, the credits run out.
        start_test();
        bank = rand_below(NUM_BANKS);
        for (int k = 0; k < 8; k++) store(k * NUM_BANKS + bank, rand_word(), '1);
        for (int k = 0; k < N5; k++) load(rand_below(8) * NUM_BANKS + bank);
        if (stalls == 0) begin
            $display("ERROR at %0t ns: single bank burst never saw ready low", $time);
            errors++;
        end
        end_test("single bank burst");

        start_test();
        for (int k = 0; k < N6; k++) begin
            idle(rand_below(4));
            kind = rand_below(4);
            case (kind)
                0: begin
                    bank = rand_below(WORDS);
                    store(bank, rand_word(), store_mask(bank));
                end
                1: load(pick_written());
                2: fetch(pick_written());
                default: issue(1'b1, pick_written(), 1'b1, 1'b0, pick_written(), '0, '0);
            endcase
        end
        end_test("random traffic");

        $display("summary: %0d tests, %0d reads, %0d responses, %0d errors",
                 tests_done, reads, resps, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
